//--- Makefile
SIM   = verilator
FLAGS = --binary --timing -j 0
TOP   = tb_rename_dispatch
FLIST = project.f
OBJ   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ)

run: compile
	@out=$$(./$(OBJ)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ)

//--- project.f
+incdir+testbench
src/rename_pkg.sv
src/rename_table.sv
src/free_list.sv
src/dispatcher.sv
src/rename_dispatch_top.sv
testbench/tb_rename_dispatch.sv

//--- src/dispatcher.sv
// Dispatcher deciding the queue pop and building the dispatch entry from both lookups
`timescale 1ns/100ps

module dispatcher (
    input  logic                  clk,
    input  logic                  rst,

    // Back-pressure levels
    input  logic                  inst_q_empty,
    input  logic                  rs_full,
    input  logic                  rob_full,

    // Instruction presented by the queue the cycle after a pop
    input  rename_pkg::areg_t     inst_rs1,
    input  rename_pkg::areg_t     inst_rs2,
    input  rename_pkg::areg_t     inst_rd,
    input  logic                  inst_has_rd,
    input  logic [31:0]           inst_pc,

    // Rename table results
    input  rename_pkg::preg_t     map_rs1,
    input  rename_pkg::preg_t     map_rs2,
    input  rename_pkg::preg_t     map_rd_old,
    input  logic                  rdy_rs1,
    input  logic                  rdy_rs2,

    // Free list head
    input  rename_pkg::preg_t     free_head,
    input  logic                  free_empty,

    // Queue pop and entry valid
    output logic                  pop_inst_q,
    output logic                  dispatch_valid,

    // Rename table lookups and update
    output rename_pkg::areg_t     lookup_rs1,
    output rename_pkg::areg_t     lookup_rs2,
    output rename_pkg::areg_t     rename_rd,
    output logic                  rename_we,
    output rename_pkg::preg_t     rename_prd,

    // Free list pop
    output logic                  alloc,

    // Dispatch entry for the reservation station and ROB
    output rename_pkg::rob_tag_t  disp_rob_tag,
    output rename_pkg::preg_t     disp_prs1,
    output rename_pkg::preg_t     disp_prs2,
    output rename_pkg::preg_t     disp_prd,
    output rename_pkg::preg_t     disp_old_prd,
    output logic                  disp_rd_en,
    output logic                  disp_rs1_ready,
    output logic                  disp_rs2_ready,
    output logic [31:0]           disp_pc
);

    import rename_pkg::*;

    // Next ROB tag, handed out in dispatch order
    rob_tag_t rob_tag_q;

    // Instruction writes a real destination
    logic need_rd;

    // Pop only when every consumer has room
    // Free list check keeps a register for the instruction popped now
    assign pop_inst_q = !inst_q_empty && !rs_full && !rob_full && !free_empty;

    // Queue data shows up one cycle after the pop
    always_ff @(posedge clk) begin
        if (rst) begin
            dispatch_valid <= 1'b0;
        end else begin
            dispatch_valid <= pop_inst_q;
        end
    end

    // One tag per dispatch, wraps with the ROB
    always_ff @(posedge clk) begin
        if (rst) begin
            rob_tag_q <= '0;
        end else if (dispatch_valid) begin
            rob_tag_q <= rob_tag_q + rob_tag_t'(1);
        end
    end

    // x0 writes and instructions without rd consume nothing
    assign need_rd = inst_has_rd && (inst_rd != '0);

    // Lookups follow the presented instruction directly
    assign lookup_rs1 = inst_rs1;
    assign lookup_rs2 = inst_rs2;
    assign rename_rd  = inst_rd;
    assign rename_prd = free_head;

    // Strobes stay low outside valid cycles
    assign alloc     = dispatch_valid && need_rd;
    assign rename_we = dispatch_valid && need_rd;

    // Entry assembly
    always_comb begin
        disp_rob_tag   = rob_tag_q;
        disp_prs1      = map_rs1;
        disp_prs2      = map_rs2;
        disp_rs1_ready = rdy_rs1;
        disp_rs2_ready = rdy_rs2;
        disp_pc        = inst_pc;
        disp_rd_en     = dispatch_valid && need_rd;
        if (need_rd) begin
            // New destination from the head, old one freed at commit
            disp_prd     = free_head;
            disp_old_prd = map_rd_old;
        end else begin
            disp_prd     = '0;
            disp_old_prd = '0;
        end
    end

endmodule

//--- src/free_list.sv
// Free list of physical register numbers kept as a circular FIFO
`timescale 1ns/100ps

module free_list (
    input  logic               clk,
    input  logic               rst,

    // Pop the head at the clock edge
    input  logic               alloc,

    // Register released by the ROB at commit
    input  logic               commit_free_valid,
    input  rename_pkg::preg_t  commit_free_prd,

    // Next register to hand out
    output rename_pkg::preg_t  free_head,
    output logic               free_empty
);

    import rename_pkg::*;

    // Storage for free register numbers
    preg_t free_q [FREE_DEPTH];

    // Read and write pointers
    free_ptr_t head_q;
    free_ptr_t tail_q;

    // Number of free registers held
    free_cnt_t count_q;

    // Storage and pointers
    always_ff @(posedge clk) begin
        if (rst) begin
            // Preload the registers not used by the identity map
            for (int i = 0; i < FREE_DEPTH; i++) begin
                free_q[i] <= preg_t'(ARCH_REGS + i);
            end
            head_q <= '0;
            // List starts full so the tail wraps back to the head
            tail_q <= '0;
        end else begin
            if (alloc) begin
                head_q <= head_q + free_ptr_t'(1);
            end
            if (commit_free_valid) begin
                free_q[tail_q] <= commit_free_prd;
                tail_q <= tail_q + free_ptr_t'(1);
            end
        end
    end

    // Occupancy moves by push minus pop
    always_ff @(posedge clk) begin
        if (rst) begin
            count_q <= free_cnt_t'(FREE_DEPTH);
        end else begin
            case ({alloc, commit_free_valid})
                2'b10:   count_q <= count_q - free_cnt_t'(1);
                2'b01:   count_q <= count_q + free_cnt_t'(1);
                default: count_q <= count_q;
            endcase
        end
    end

    // Head is visible without a pop
    assign free_head = free_q[head_q];

    // Empty also covers the last entry being taken this cycle
    // An instruction popped now is dispatched next cycle and needs a register left over
    // A push this cycle only counts from the next cycle on
    assign free_empty = (count_q == '0) || ((count_q == free_cnt_t'(1)) && alloc);

endmodule

//--- src/rename_dispatch_top.sv
// Rename and dispatch stage joining the alias table, free list and dispatcher
`timescale 1ns/100ps

module rename_dispatch_top (
    input  logic                  clk,
    input  logic                  rst,

    // Back-pressure levels
    input  logic                  inst_q_empty,
    input  logic                  rs_full,
    input  logic                  rob_full,

    // Instruction from the queue
    input  rename_pkg::areg_t     inst_rs1,
    input  rename_pkg::areg_t     inst_rs2,
    input  rename_pkg::areg_t     inst_rd,
    input  logic                  inst_has_rd,
    input  logic [31:0]           inst_pc,

    // Commit frees and writeback
    input  logic                  commit_free_valid,
    input  rename_pkg::preg_t     commit_free_prd,
    input  logic                  wb_valid,
    input  rename_pkg::preg_t     wb_prd,

    // Queue pop and dispatch entry
    output logic                  pop_inst_q,
    output logic                  dispatch_valid,
    output rename_pkg::rob_tag_t  disp_rob_tag,
    output rename_pkg::preg_t     disp_prs1,
    output rename_pkg::preg_t     disp_prs2,
    output rename_pkg::preg_t     disp_prd,
    output rename_pkg::preg_t     disp_old_prd,
    output logic                  disp_rd_en,
    output logic                  disp_rs1_ready,
    output logic                  disp_rs2_ready,
    output logic [31:0]           disp_pc
);

    import rename_pkg::*;

    // Dispatcher to rename table
    areg_t lookup_rs1;
    areg_t lookup_rs2;
    areg_t rename_rd;
    logic  rename_we;
    preg_t rename_prd;

    // Rename table results
    preg_t map_rs1;
    preg_t map_rs2;
    preg_t map_rd_old;
    logic  rdy_rs1;
    logic  rdy_rs2;

    // Free list handshake
    logic  alloc;
    preg_t free_head;
    logic  free_empty;

    rename_table u_rename_table (.*);

    free_list u_free_list (.*);

    dispatcher u_dispatcher (.*);

endmodule

//--- src/rename_pkg.sv
// Rename package with register file sizes, tag widths and shared index types
package rename_pkg;

    // Architectural register file of RV32I
    localparam int ARCH_REGS = 32;

    // Physical register file, twice the architectural count
    localparam int PHYS_REGS = 64;

    // Registers not mapped at reset sit in the free list
    localparam int FREE_DEPTH = PHYS_REGS - ARCH_REGS;

    // Reorder buffer entries
    localparam int ROB_DEPTH = 8;

    // Index widths
    localparam int AREG_W = $clog2(ARCH_REGS);
    localparam int PREG_W = $clog2(PHYS_REGS);
    localparam int ROB_TAG_W = $clog2(ROB_DEPTH);

    // Free list pointer and occupancy widths
    // Count needs one extra bit to hold a full list
    localparam int FREE_PTR_W = $clog2(FREE_DEPTH);
    localparam int FREE_CNT_W = $clog2(FREE_DEPTH + 1);

    // Architectural register index
    typedef logic [AREG_W-1:0] areg_t;

    // Physical register index
    typedef logic [PREG_W-1:0] preg_t;

    // Reorder buffer tag
    typedef logic [ROB_TAG_W-1:0] rob_tag_t;

    // Free list pointer
    typedef logic [FREE_PTR_W-1:0] free_ptr_t;

    // Free list occupancy
    typedef logic [FREE_CNT_W-1:0] free_cnt_t;

endpackage

//--- src/rename_table.sv
// Register alias table holding the arch-to-phys map and per-register ready bits
`timescale 1ns/100ps

module rename_table (
    input  logic               clk,
    input  logic               rst,

    // Source lookups for the instruction being dispatched
    input  rename_pkg::areg_t  lookup_rs1,
    input  rename_pkg::areg_t  lookup_rs2,

    // New mapping for the destination
    input  rename_pkg::areg_t  rename_rd,
    input  logic               rename_we,
    input  rename_pkg::preg_t  rename_prd,

    // Writeback marks a physical register ready
    input  logic               wb_valid,
    input  rename_pkg::preg_t  wb_prd,

    // Lookup results
    output rename_pkg::preg_t  map_rs1,
    output rename_pkg::preg_t  map_rs2,
    output rename_pkg::preg_t  map_rd_old,
    output logic               rdy_rs1,
    output logic               rdy_rs2
);

    import rename_pkg::*;

    // Current mapping of each architectural register
    preg_t map_q [ARCH_REGS];

    // Set when the physical register holds its final value
    logic [PHYS_REGS-1:0] ready_q;

    // Writeback hits on each source, used for same-cycle bypass
    logic wb_hit_rs1;
    logic wb_hit_rs2;

    // Map update
    // x0 never gets a write since the dispatcher skips zero destinations
    always_ff @(posedge clk) begin
        if (rst) begin
            // Identity map out of reset
            for (int i = 0; i < ARCH_REGS; i++) begin
                map_q[i] <= preg_t'(i);
            end
        end else if (rename_we) begin
            map_q[rename_rd] <= rename_prd;
        end
    end

    // Ready bits
    always_ff @(posedge clk) begin
        if (rst) begin
            // Every register starts with a committed value
            ready_q <= '1;
        end else begin
            if (wb_valid) begin
                ready_q[wb_prd] <= 1'b1;
            end
            // Placed last so a rename beats a writeback to the same register
            if (rename_we) begin
                ready_q[rename_prd] <= 1'b0;
            end
        end
    end

    // Combinational map reads
    assign map_rs1 = map_q[lookup_rs1];
    assign map_rs2 = map_q[lookup_rs2];

    // Old mapping of the destination, freed by the ROB at commit
    assign map_rd_old = map_q[rename_rd];

    // Writeback landing this cycle on a looked-up source
    assign wb_hit_rs1 = wb_valid && (wb_prd == map_rs1);
    assign wb_hit_rs2 = wb_valid && (wb_prd == map_rs2);

    // Ready with bypass
    assign rdy_rs1 = ready_q[map_rs1] || wb_hit_rs1;
    assign rdy_rs2 = ready_q[map_rs2] || wb_hit_rs2;

endmodule

//--- testbench/tb_checks.svh
// Compare tasks for physical registers, ROB tags, program counters and single bits
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Physical register result
task automatic check_preg(input string what, input rename_pkg::preg_t exp,
                          input rename_pkg::preg_t act);
    if (act !== exp) begin
        $display("mismatch %s %s: expected %0d actual %0d", test_name, what, exp, act);
        $display("sim failed");
        $fatal(1, "physical register compare");
    end
endtask

// ROB tag result
task automatic check_tag(input string what, input rename_pkg::rob_tag_t exp,
                         input rename_pkg::rob_tag_t act);
    if (act !== exp) begin
        $display("mismatch %s %s: expected %0d actual %0d", test_name, what, exp, act);
        $display("sim failed");
        $fatal(1, "ROB tag compare");
    end
endtask

// Program counter carried into the entry
task automatic check_pc(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
        $display("mismatch %s %s: expected %h actual %h", test_name, what, exp, act);
        $display("sim failed");
        $fatal(1, "program counter compare");
    end
endtask

// Strobes, ready bits and other flags
task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
        $display("mismatch %s %s: expected %b actual %b", test_name, what, exp, act);
        $display("sim failed");
        $fatal(1, "bit compare");
    end
endtask

`endif

//--- testbench/tb_rename_dispatch.sv
// Testbench for the rename and dispatch stage with queue model and reference rename model
`timescale 1ns/100ps

module tb_rename_dispatch;

    import rename_pkg::*;

    // Queued instruction, with an optional writeback launched when it is presented
    typedef struct packed {
        areg_t       rs1;
        areg_t       rs2;
        areg_t       rd;
        logic        has_rd;
        logic [31:0] pc;
        logic        wb_en;
        preg_t       wb_p;
    } inst_t;

    logic        clk;
    logic        rst;
    logic        inst_q_empty;
    logic        rs_full;
    logic        rob_full;
    areg_t       inst_rs1;
    areg_t       inst_rs2;
    areg_t       inst_rd;
    logic        inst_has_rd;
    logic [31:0] inst_pc;
    logic        commit_free_valid;
    preg_t       commit_free_prd;
    logic        wb_valid;
    preg_t       wb_prd;

    logic        pop_inst_q;
    logic        dispatch_valid;
    rob_tag_t    disp_rob_tag;
    preg_t       disp_prs1;
    preg_t       disp_prs2;
    preg_t       disp_prd;
    preg_t       disp_old_prd;
    logic        disp_rd_en;
    logic        disp_rs1_ready;
    logic        disp_rs2_ready;
    logic [31:0] disp_pc;

    // Pending instructions and commit frees
    inst_t inst_q[$];
    preg_t free_req[$];
    logic  stall_empty;
    inst_t cur;

    // Reference rename state
    preg_t                m_map [ARCH_REGS];
    logic [PHYS_REGS-1:0] m_rdy;
    preg_t                m_free[$];
    preg_t                old_list[$];
    rob_tag_t             m_tag;
    logic                 exp_valid;
    int                   disp_count;

    // Last dispatch as seen on the outputs
    preg_t    last_prs1;
    preg_t    last_prs2;
    preg_t    last_prd;
    preg_t    last_old_prd;
    logic     last_rd_en;
    logic     last_rdy1;
    logic     last_rdy2;
    rob_tag_t last_tag;

    string test_name;
    int    seed;
    int    pc_next;

    `include "tb_checks.svh"

    rename_dispatch_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Instruction queue model, presents the next entry the cycle after a pop
    initial begin : queue_model
        inst_t nxt;
        inst_q_empty      = 1'b1;
        inst_rs1          = '0;
        inst_rs2          = '0;
        inst_rd           = '0;
        inst_has_rd       = 1'b0;
        inst_pc           = '0;
        commit_free_valid = 1'b0;
        commit_free_prd   = '0;
        wb_valid          = 1'b0;
        wb_prd            = '0;
        cur               = '0;
        forever begin
            @(posedge clk);
            wb_valid          <= 1'b0;
            commit_free_valid <= 1'b0;
            if (pop_inst_q && (inst_q.size() > 0)) begin
                nxt = inst_q.pop_front();
                cur         <= nxt;
                inst_rs1    <= nxt.rs1;
                inst_rs2    <= nxt.rs2;
                inst_rd     <= nxt.rd;
                inst_has_rd <= nxt.has_rd;
                inst_pc     <= nxt.pc;
                wb_valid    <= nxt.wb_en;
                wb_prd      <= nxt.wb_p;
            end
            // One commit free per cycle
            if (free_req.size() > 0) begin
                commit_free_valid <= 1'b1;
                commit_free_prd   <= free_req.pop_front();
            end
            inst_q_empty <= stall_empty || (inst_q.size() == 0);
        end
    end

    // Reference model and per-cycle checks, sampled mid-cycle
    always @(negedge clk) begin : monitor
        logic  need;
        logic  free_ok;
        logic  exp_pop;
        logic  r1;
        logic  r2;
        preg_t head;
        if (rst) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                m_map[i] = preg_t'(i);
            end
            m_rdy = '1;
            m_free.delete();
            for (int i = 0; i < FREE_DEPTH; i++) begin
                m_free.push_back(preg_t'(ARCH_REGS + i));
            end
            old_list.delete();
            m_tag      = '0;
            exp_valid  = 1'b0;
            disp_count = 0;
        end else begin
            need = cur.has_rd && (cur.rd != '0);
            // A register must remain for the instruction popped now
            free_ok = (m_free.size() > 1) || ((m_free.size() == 1) && !(exp_valid && need));
            exp_pop = !inst_q_empty && !rs_full && !rob_full && free_ok;
            check_bit("dispatch_valid", exp_valid, dispatch_valid);
            check_bit("pop_inst_q", exp_pop, pop_inst_q);
            if (exp_valid) begin
                r1 = m_rdy[m_map[cur.rs1]] || (wb_valid && (wb_prd == m_map[cur.rs1]));
                r2 = m_rdy[m_map[cur.rs2]] || (wb_valid && (wb_prd == m_map[cur.rs2]));
                check_preg("disp_prs1", m_map[cur.rs1], disp_prs1);
                check_preg("disp_prs2", m_map[cur.rs2], disp_prs2);
                check_bit("disp_rs1_ready", r1, disp_rs1_ready);
                check_bit("disp_rs2_ready", r2, disp_rs2_ready);
                check_tag("disp_rob_tag", m_tag, disp_rob_tag);
                check_bit("disp_rd_en", need, disp_rd_en);
                check_pc("disp_pc", cur.pc, disp_pc);
                if (need) begin
                    check_preg("disp_prd", m_free[0], disp_prd);
                    check_preg("disp_old_prd", m_map[cur.rd], disp_old_prd);
                end else begin
                    check_preg("disp_prd", '0, disp_prd);
                    check_preg("disp_old_prd", '0, disp_old_prd);
                end
                last_prs1    = disp_prs1;
                last_prs2    = disp_prs2;
                last_prd     = disp_prd;
                last_old_prd = disp_old_prd;
                last_rd_en   = disp_rd_en;
                last_rdy1    = disp_rs1_ready;
                last_rdy2    = disp_rs2_ready;
                last_tag     = disp_rob_tag;
            end
            // Edge effects, writeback first so a rename wins
            if (wb_valid) begin
                m_rdy[wb_prd] = 1'b1;
            end
            if (exp_valid && need) begin
                head = m_free.pop_front();
                old_list.push_back(m_map[cur.rd]);
                m_map[cur.rd] = head;
                m_rdy[head]   = 1'b0;
            end
            if (exp_valid) begin
                m_tag      = m_tag + rob_tag_t'(1);
                disp_count = disp_count + 1;
            end
            if (commit_free_valid) begin
                m_free.push_back(commit_free_prd);
            end
            exp_valid = exp_pop;
        end
    end

    function automatic areg_t rand_reg();
        return areg_t'($unsigned($random(seed)));
    endfunction

    function automatic areg_t rand_rd();
        return areg_t'(1 + ($unsigned($random(seed)) % 31));
    endfunction

    // Queue one instruction between edges
    task automatic push_inst(input areg_t rs1, input areg_t rs2, input areg_t rd,
                             input logic has_rd, input logic wb_en, input preg_t wb_p);
        inst_t t;
        @(negedge clk);
        t.rs1    = rs1;
        t.rs2    = rs2;
        t.rd     = rd;
        t.has_rd = has_rd;
        t.pc     = 32'(pc_next);
        t.wb_en  = wb_en;
        t.wb_p   = wb_p;
        pc_next  = pc_next + 4;
        inst_q.push_back(t);
    endtask

    task automatic wait_dispatches(input int target);
        int n;
        n = 0;
        while ((disp_count < target) && (n < 200)) begin
            @(posedge clk);
            n++;
        end
        if (disp_count < target) begin
            $display("timeout in %s waiting for dispatch %0d", test_name, target);
            $display("sim failed");
            $fatal(1, "dispatch wait timed out");
        end
    endtask

    task automatic test_reset_first();
        test_name = "reset_first";
        check_bit("dispatch_valid after reset", 1'b0, dispatch_valid);
        push_inst(areg_t'(1), areg_t'(2), areg_t'(5), 1'b1, 1'b0, '0);
        wait_dispatches(1);
        check_preg("first prd", preg_t'(32), last_prd);
        check_preg("first prs1", preg_t'(1), last_prs1);
        check_preg("first prs2", preg_t'(2), last_prs2);
        check_bit("first rs1 ready", 1'b1, last_rdy1);
        check_bit("first rs2 ready", 1'b1, last_rdy2);
        check_tag("first tag", '0, last_tag);
        check_preg("first old prd", preg_t'(5), last_old_prd);
    endtask

    task automatic test_dependency();
        int c0;
        test_name = "dependency";
        c0 = disp_count;
        push_inst(areg_t'(5), areg_t'(3), areg_t'(6), 1'b1, 1'b0, '0);
        wait_dispatches(c0 + 1);
        check_preg("renamed source", preg_t'(32), last_prs1);
        check_bit("source pending", 1'b0, last_rdy1);
        // Writeback of p32 lands in the lookup cycle
        push_inst(areg_t'(5), areg_t'(0), areg_t'(7), 1'b1, 1'b1, preg_t'(32));
        wait_dispatches(c0 + 2);
        check_preg("bypass source", preg_t'(32), last_prs1);
        check_bit("bypass ready", 1'b1, last_rdy1);
    endtask

    task automatic test_no_dest();
        int    c0;
        preg_t head;
        test_name = "no_dest";
        c0   = disp_count;
        head = m_free[0];
        push_inst(areg_t'(1), areg_t'(2), areg_t'(9), 1'b0, 1'b0, '0);
        wait_dispatches(c0 + 1);
        check_bit("no rd enable", 1'b0, last_rd_en);
        check_preg("no rd prd", '0, last_prd);
        push_inst(areg_t'(3), areg_t'(4), areg_t'(0), 1'b1, 1'b0, '0);
        wait_dispatches(c0 + 2);
        check_bit("x0 rd enable", 1'b0, last_rd_en);
        check_preg("x0 prd", '0, last_prd);
        push_inst(areg_t'(1), areg_t'(1), areg_t'(10), 1'b1, 1'b0, '0);
        wait_dispatches(c0 + 3);
        check_preg("head kept", head, last_prd);
    endtask

    task automatic test_backpressure();
        int c0;
        test_name = "backpressure";
        for (int kind = 0; kind < 3; kind++) begin
            c0 = disp_count;
            @(posedge clk);
            case (kind)
                0:       rs_full <= 1'b1;
                1:       rob_full <= 1'b1;
                default: stall_empty <= 1'b1;
            endcase
            push_inst(rand_reg(), rand_reg(), rand_rd(), 1'b1, 1'b0, '0);
            push_inst(rand_reg(), rand_reg(), rand_rd(), 1'b1, 1'b0, '0);
            @(negedge clk);
            check_bit("pop under stall", 1'b0, pop_inst_q);
            repeat (3) @(negedge clk);
            check_bit("no dispatch under stall", 1'b1, disp_count == c0);
            @(posedge clk);
            rs_full     <= 1'b0;
            rob_full    <= 1'b0;
            stall_empty <= 1'b0;
            wait_dispatches(c0 + 2);
        end
    endtask

    task automatic test_rob_tags();
        int       c0;
        rob_tag_t t0;
        test_name = "rob_tags";
        // Tag of a dispatch is the number of earlier dispatches modulo the ROB depth
        t0 = rob_tag_t'(disp_count);
        for (int k = 0; k < 9; k++) begin
            c0 = disp_count;
            push_inst(rand_reg(), rand_reg(), '0, 1'b0, 1'b0, '0);
            wait_dispatches(c0 + 1);
            check_tag("tag step", rob_tag_t'(int'(t0) + k), last_tag);
        end
    endtask

    task automatic test_exhaustion();
        int    c0;
        int    n;
        preg_t a;
        preg_t b;
        test_name = "exhaustion";
        c0 = disp_count;
        n  = m_free.size();
        for (int k = 0; k < n + 2; k++) begin
            push_inst(rand_reg(), rand_reg(), rand_rd(), 1'b1, 1'b0, '0);
        end
        wait_dispatches(c0 + n);
        repeat (4) @(negedge clk);
        check_bit("pop with empty list", 1'b0, pop_inst_q);
        check_bit("dispatch held", 1'b1, disp_count == c0 + n);
        // Superseded mappings go back in FIFO order
        a = old_list[0];
        b = old_list[1];
        @(negedge clk);
        free_req.push_back(a);
        free_req.push_back(b);
        wait_dispatches(c0 + n + 1);
        check_preg("first recycled", a, last_prd);
        wait_dispatches(c0 + n + 2);
        check_preg("second recycled", b, last_prd);
    endtask

    initial begin
        rst         = 1'b1;
        rs_full     = 1'b0;
        rob_full    = 1'b0;
        stall_empty = 1'b0;
        seed        = 61;
        pc_next     = 32'h1000;
        test_name   = "reset";
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        test_reset_first();
        test_dependency();
        test_no_dest();
        test_backpressure();
        test_rob_tags();
        test_exhaustion();
        repeat (2) @(posedge clk);
        $display("sim passed");
        $finish;
    end

endmodule
